/* source/lsu_pkg.sv */
// load unit package: queue depth, index and payload types
// size codes, DTLB permission bits, exception causes, slot states
package lsu_pkg;

    localparam int LQ_DEPTH = 8;                      // load queue slots
    localparam int LQ_IDX_W = $clog2(LQ_DEPTH);       // slot index bits

    typedef logic [LQ_IDX_W-1:0] lq_idx_t;            // slot / load id
    typedef logic [63:0]         addr_t;              // virtual or physical
    typedef logic [63:0]         data_t;
    typedef logic [2:0]          ld_size_t;           // [1:0] size, [2] unsigned
    typedef logic [7:0]          perm_t;              // DTLB permission byte
    typedef logic [7:0]          cause_t;             // {2'b10, code} on exception

    // access size in the low two bits of ld_size_t
    localparam logic [1:0] SZ_BYTE = 2'd0;
    localparam logic [1:0] SZ_HALF = 2'd1;
    localparam logic [1:0] SZ_WORD = 2'd2;
    localparam logic [1:0] SZ_DWRD = 2'd3;

    localparam perm_t PERM_V = 8'b0000_0001;          // entry valid
    localparam perm_t PERM_R = 8'b0000_0010;          // readable
    localparam perm_t PERM_A = 8'b0100_0000;          // accessed

    // a load needs all of V, R and A
    localparam perm_t PERM_LOAD_MASK = PERM_V | PERM_R | PERM_A;

    localparam cause_t CAUSE_NONE            = 8'h00;
    localparam cause_t CAUSE_LOAD_MISALIGNED = {2'b10, 6'd4};
    localparam cause_t CAUSE_LOAD_PAGE_FAULT = {2'b10, 6'd13};

    typedef enum logic [2:0] {
        FREE,           // unallocated
        TRANSLATE,      // waiting for the DTLB port
        TRANS_WAIT,     // translation in flight
        ACCESS,         // waiting for the cache port
        ACCESS_WAIT,    // cache read in flight
        READY,          // result waiting for claim
        CLAIMED         // result taken, waiting for commit
    } slot_state_e;

endpackage

/* source/lq_bus_if.sv */
// load queue bus: allocation from dispatch, per-slot status,
// and the grants and one-hot events from the scheduler
`timescale 1ns/1ps

interface lq_bus_if import lsu_pkg::*;;

    // allocation of an issued load
    logic     alloc_valid;
    lq_idx_t  alloc_idx;
    addr_t    alloc_vaddr;
    ld_size_t alloc_size;
    logic     alloc_misaligned;

    // per-slot status, element i driven by slot i
    logic [LQ_DEPTH-1:0]  want_trans;
    logic [LQ_DEPTH-1:0]  want_access;
    logic [LQ_DEPTH-1:0]  has_result;
    addr_t [LQ_DEPTH-1:0] slot_vaddr;
    addr_t [LQ_DEPTH-1:0] slot_paddr;
    data_t [LQ_DEPTH-1:0] slot_data;
    cause_t [LQ_DEPTH-1:0] slot_cause;

    // grants and decoded events, one bit per slot
    logic [LQ_DEPTH-1:0] trans_grant;
    logic [LQ_DEPTH-1:0] access_grant;
    logic [LQ_DEPTH-1:0] result_sel;
    logic [LQ_DEPTH-1:0] trans_done;
    logic [LQ_DEPTH-1:0] access_done;
    logic [LQ_DEPTH-1:0] claimed;
    logic [LQ_DEPTH-1:0] committed;

    modport dispatch (
        output alloc_valid, alloc_idx, alloc_vaddr, alloc_size, alloc_misaligned
    );

    modport slot (
        input  alloc_valid, alloc_idx, alloc_vaddr, alloc_size, alloc_misaligned,
        input  trans_grant, access_grant, trans_done, access_done, claimed, committed,
        output want_trans, want_access, has_result,
        output slot_vaddr, slot_paddr, slot_data, slot_cause
    );

    modport scheduler (
        input  want_trans, want_access, has_result,
        input  slot_vaddr, slot_paddr, slot_data, slot_cause,
        output trans_grant, access_grant, result_sel,
        output trans_done, access_done, claimed, committed
    );

endinterface

/* source/load_dispatch.sv */
// load dispatch: flush masking and alignment check of issued loads,
// drives the allocation side of the queue bus
`timescale 1ns/1ps

module load_dispatch import lsu_pkg::*; (
    input  logic     clk,
    input  logic     issue_valid,
    input  lq_idx_t  issue_ldid,
    input  addr_t    issue_vaddr,
    input  ld_size_t issue_size,
    input  logic     flush,
    lq_bus_if.dispatch bus
);

    logic misaligned;       // address not a multiple of the access size

    always_comb begin
        case (issue_size[1:0])
            SZ_HALF: misaligned = issue_vaddr[0];
            SZ_WORD: misaligned = |issue_vaddr[1:0];
            SZ_DWRD: misaligned = |issue_vaddr[2:0];
            default: misaligned = 1'b0;        // bytes are always aligned
        endcase
    end

    // an issue in the flush cycle belongs to the squashed path
    assign bus.alloc_valid      = issue_valid & ~flush;
    assign bus.alloc_idx        = issue_ldid;
    assign bus.alloc_vaddr      = issue_vaddr;
    assign bus.alloc_size       = issue_size;
    assign bus.alloc_misaligned = misaligned;

endmodule

/* source/load_slot.sv */
// load queue slot: state machine, addresses, size code,
// extended load data and exception cause of one load
`timescale 1ns/1ps

module load_slot import lsu_pkg::*; #(
    parameter int SLOT_IDX = 0
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  flush,
    input  addr_t dt_padd,
    input  perm_t dt_perm,
    input  data_t dc_rdat,
    lq_bus_if.slot bus
);

    slot_state_e state_q;
    addr_t       vaddr_q;
    addr_t       paddr_q;
    ld_size_t    size_q;
    data_t       data_q;
    cause_t      cause_q;

    logic alloc_hit;        // this slot is allocated this cycle
    logic trans_hit;        // DTLB answer for this slot
    logic access_hit;       // cache answer for this slot
    logic perm_ok;

    // sign or zero extension of data already shifted to byte 0
    function automatic data_t extend(ld_size_t size, data_t raw);
        data_t ext;
        case (size[1:0])
            SZ_BYTE: ext = size[2] ? {56'd0, raw[7:0]}  : {{56{raw[7]}}, raw[7:0]};
            SZ_HALF: ext = size[2] ? {48'd0, raw[15:0]} : {{48{raw[15]}}, raw[15:0]};
            SZ_WORD: ext = size[2] ? {32'd0, raw[31:0]} : {{32{raw[31]}}, raw[31:0]};
            default: ext = raw;                 // double passes through
        endcase
        return ext;
    endfunction

    assign alloc_hit  = bus.alloc_valid && (bus.alloc_idx == lq_idx_t'(SLOT_IDX));
    assign trans_hit  = bus.trans_done[SLOT_IDX] && (state_q == TRANS_WAIT);
    assign access_hit = bus.access_done[SLOT_IDX] && (state_q == ACCESS_WAIT);
    assign perm_ok    = (dt_perm & PERM_LOAD_MASK) == PERM_LOAD_MASK;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state_q <= FREE;
        end else if (alloc_hit) begin
            state_q <= bus.alloc_misaligned ? READY : TRANSLATE;
        end else if (bus.committed[SLOT_IDX]) begin
            state_q <= FREE;
        end else begin
            case (state_q)
                TRANSLATE:   if (bus.trans_grant[SLOT_IDX]) state_q <= TRANS_WAIT;
                TRANS_WAIT:  if (trans_hit) state_q <= perm_ok ? ACCESS : READY;
                ACCESS:      if (bus.access_grant[SLOT_IDX]) state_q <= ACCESS_WAIT;
                ACCESS_WAIT: if (access_hit) state_q <= READY;
                READY:       if (bus.claimed[SLOT_IDX]) state_q <= CLAIMED;
                default:     state_q <= state_q;   // FREE and CLAIMED hold
            endcase
        end
    end

    // payload of the load
    always_ff @(posedge clk) begin
        if (alloc_hit) begin
            vaddr_q <= bus.alloc_vaddr;
            size_q  <= bus.alloc_size;
            data_q  <= '0;
            cause_q <= bus.alloc_misaligned ? CAUSE_LOAD_MISALIGNED : CAUSE_NONE;
        end else begin
            if (trans_hit) begin
                paddr_q <= dt_padd;
                if (!perm_ok) cause_q <= CAUSE_LOAD_PAGE_FAULT;
            end
            if (access_hit) data_q <= extend(size_q, dc_rdat);
        end
    end

    assign bus.want_trans[SLOT_IDX]  = state_q == TRANSLATE;
    assign bus.want_access[SLOT_IDX] = state_q == ACCESS;
    assign bus.has_result[SLOT_IDX]  = state_q == READY;
    assign bus.slot_vaddr[SLOT_IDX]  = vaddr_q;
    assign bus.slot_paddr[SLOT_IDX]  = paddr_q;
    assign bus.slot_data[SLOT_IDX]   = data_q;
    assign bus.slot_cause[SLOT_IDX]  = cause_q;

endmodule

/* source/lq_scheduler.sv */
// load queue scheduler: queue front, oldest-first picks for DTLB,
// cache and result ports, and one-hot slot events
`timescale 1ns/1ps

module lq_scheduler import lsu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    lq_bus_if.scheduler bus,
    input  logic    dt_resp_valid,
    input  lq_idx_t dt_resp_id,
    input  logic    dc_resp_valid,
    input  lq_idx_t dc_resp_id,
    input  logic    claim,
    input  logic    commit_valid,
    output logic    dt_rqst_valid,
    output lq_idx_t dt_rqst_id,
    output addr_t   dt_vadd,
    output logic    dc_rqst_valid,
    output lq_idx_t dc_rqst_id,
    output addr_t   dc_addr,
    output logic    res_valid,
    output lq_idx_t res_ldid,
    output data_t   res_data,
    output cause_t  res_cause
);

    lq_idx_t front_q;                       // oldest uncommitted load
    logic    held_q;                        // result shown but not claimed
    lq_idx_t held_idx_q;

    logic [LQ_IDX_W:0] trans_pick;          // {found, index}
    logic [LQ_IDX_W:0] access_pick;
    logic [LQ_IDX_W:0] ready_pick;
    logic              res_hold;

    // first requesting slot counted from the front
    function automatic logic [LQ_IDX_W:0] pick_oldest(logic [LQ_DEPTH-1:0] req,
                                                      lq_idx_t front);
        lq_idx_t           idx;
        logic [LQ_IDX_W:0] pick;
        pick = '0;
        for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
            idx = front + lq_idx_t'(i);
            if (req[idx]) pick = {1'b1, idx};
        end
        return pick;
    endfunction

    function automatic logic [LQ_DEPTH-1:0] one_hot(lq_idx_t idx);
        return {{(LQ_DEPTH-1){1'b0}}, 1'b1} << idx;
    endfunction

    always_comb begin
        trans_pick  = pick_oldest(bus.want_trans, front_q);
        access_pick = pick_oldest(bus.want_access, front_q);
        ready_pick  = pick_oldest(bus.has_result, front_q);
        res_hold    = held_q & bus.has_result[held_idx_q];   // keep the shown result
    end

    assign dt_rqst_valid = trans_pick[LQ_IDX_W] & ~flush;
    assign dt_rqst_id    = trans_pick[LQ_IDX_W-1:0];
    assign dt_vadd       = bus.slot_vaddr[dt_rqst_id];

    assign dc_rqst_valid = access_pick[LQ_IDX_W] & ~flush;
    assign dc_rqst_id    = access_pick[LQ_IDX_W-1:0];
    assign dc_addr       = bus.slot_paddr[dc_rqst_id];

    assign res_valid = (res_hold | ready_pick[LQ_IDX_W]) & ~flush;
    assign res_ldid  = res_hold ? held_idx_q : ready_pick[LQ_IDX_W-1:0];
    assign res_data  = bus.slot_data[res_ldid];
    assign res_cause = bus.slot_cause[res_ldid];

    assign bus.trans_grant  = dt_rqst_valid ? one_hot(dt_rqst_id) : '0;
    assign bus.access_grant = dc_rqst_valid ? one_hot(dc_rqst_id) : '0;
    assign bus.result_sel   = res_valid ? one_hot(res_ldid) : '0;
    assign bus.trans_done   = dt_resp_valid ? one_hot(dt_resp_id) : '0;
    assign bus.access_done  = dc_resp_valid ? one_hot(dc_resp_id) : '0;
    assign bus.claimed      = claim ? bus.result_sel : '0;
    assign bus.committed    = commit_valid ? one_hot(front_q) : '0;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            front_q <= '0;
            held_q  <= 1'b0;
        end else begin
            if (commit_valid) front_q <= front_q + 1'b1;
            held_q <= res_valid & ~claim;       // back-pressure on the result port
        end
    end

    always_ff @(posedge clk) begin
        held_idx_q <= res_ldid;
    end

endmodule

/* source/lsu_load_unit.sv */
// load unit top: dispatch, LQ_DEPTH load slots and the scheduler
// joined by the queue bus, with plain DTLB, cache and result ports
`timescale 1ns/1ps

module lsu_load_unit import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    // issue from the reorder buffer
    input  logic     issue_valid,
    input  lq_idx_t  issue_ldid,
    input  addr_t    issue_vaddr,
    input  ld_size_t issue_size,
    // DTLB port
    output logic     dt_rqst_valid,
    output lq_idx_t  dt_rqst_id,
    output addr_t    dt_vadd,
    input  logic     dt_resp_valid,
    input  lq_idx_t  dt_resp_id,
    input  addr_t    dt_padd,
    input  perm_t    dt_perm,
    // data cache port
    output logic     dc_rqst_valid,
    output lq_idx_t  dc_rqst_id,
    output addr_t    dc_addr,
    input  logic     dc_resp_valid,
    input  lq_idx_t  dc_resp_id,
    input  data_t    dc_rdat,
    // result and commit
    output logic     res_valid,
    output lq_idx_t  res_ldid,
    output data_t    res_data,
    output cause_t   res_cause,
    input  logic     claim,
    input  logic     commit_valid
);

    lq_bus_if bus ();

    load_dispatch u_dispatch (
        .clk         (clk),
        .issue_valid (issue_valid),
        .issue_ldid  (issue_ldid),
        .issue_vaddr (issue_vaddr),
        .issue_size  (issue_size),
        .flush       (flush),
        .bus         (bus.dispatch)
    );

    for (genvar i = 0; i < LQ_DEPTH; i++) begin : g_slot
        load_slot #(
            .SLOT_IDX (i)
        ) u_slot (
            .clk     (clk),
            .rst     (rst),
            .flush   (flush),
            .dt_padd (dt_padd),
            .dt_perm (dt_perm),
            .dc_rdat (dc_rdat),
            .bus     (bus.slot)
        );
    end

    lq_scheduler u_scheduler (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .bus           (bus.scheduler),
        .dt_resp_valid (dt_resp_valid),
        .dt_resp_id    (dt_resp_id),
        .dc_resp_valid (dc_resp_valid),
        .dc_resp_id    (dc_resp_id),
        .claim         (claim),
        .commit_valid  (commit_valid),
        .dt_rqst_valid (dt_rqst_valid),
        .dt_rqst_id    (dt_rqst_id),
        .dt_vadd       (dt_vadd),
        .dc_rqst_valid (dc_rqst_valid),
        .dc_rqst_id    (dc_rqst_id),
        .dc_addr       (dc_addr),
        .res_valid     (res_valid),
        .res_ldid      (res_ldid),
        .res_data      (res_data),
        .res_cause     (res_cause)
    );

endmodule

/* sim/lsu_load_properties.sv */
// concurrent assertions on the load unit ports: result stability,
// quiet outputs after reset, no repeated cache request per index
`timescale 1ns/1ps

module lsu_load_properties import lsu_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    flush,
    input logic    claim,
    input logic    dt_rqst_valid,
    input logic    dc_rqst_valid,
    input lq_idx_t dc_rqst_id,
    input logic    dc_resp_valid,
    input lq_idx_t dc_resp_id,
    input logic    res_valid,
    input lq_idx_t res_ldid,
    input data_t   res_data,
    input cause_t  res_cause
);

    logic [LQ_DEPTH-1:0] dc_open;   // cache reads in flight per index

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dc_open <= '0;
        end else begin
            if (dc_resp_valid) dc_open[dc_resp_id] <= 1'b0;
            if (dc_rqst_valid) dc_open[dc_rqst_id] <= 1'b1;
        end
    end

    res_held: assert property (@(posedge clk) disable iff (rst)
        res_valid && !claim |=> flush || (res_valid && $stable(res_ldid)
            && $stable(res_data) && $stable(res_cause)))
        else $error("result changed before claim");

    quiet_after_rst: assert property (@(posedge clk)
        rst |=> !dt_rqst_valid && !dc_rqst_valid && !res_valid)
        else $error("output valid high after reset");

    dc_no_repeat: assert property (@(posedge clk) disable iff (rst)
        dc_rqst_valid |-> !dc_open[dc_rqst_id])
        else $error("cache request repeated without a response");

endmodule

bind lsu_load_unit lsu_load_properties u_props (.*);

/* sim/tb_lsu_load.sv */
// load unit testbench: DTLB and cache models with random delays,
// result monitor and directed tests
`timescale 1ns/1ps

module tb_lsu_load import lsu_pkg::*;;

    logic     clk, rst, flush, claim, commit_valid;
    logic     issue_valid;
    lq_idx_t  issue_ldid;
    addr_t    issue_vaddr;
    ld_size_t issue_size;
    logic     dt_rqst_valid, dc_rqst_valid;
    lq_idx_t  dt_rqst_id, dc_rqst_id, res_ldid;
    addr_t    dt_vadd, dc_addr;
    data_t    res_data;
    logic     res_valid;
    cause_t   res_cause;
    // model outputs start idle until the first clock edge
    logic     dt_resp_valid = 1'b0;
    logic     dc_resp_valid = 1'b0;
    lq_idx_t  dt_resp_id    = '0;
    lq_idx_t  dc_resp_id    = '0;
    addr_t    dt_padd       = '0;
    perm_t    dt_perm       = '0;
    data_t    dc_rdat       = '0;

    logic   pending [LQ_DEPTH];    // issued and not yet committed
    logic   got [LQ_DEPTH];        // result claimed
    logic   ready [LQ_DEPTH];      // result due from the DUT
    logic   fault [LQ_DEPTH];      // DTLB drops R for this index
    data_t  exp_data [LQ_DEPTH];
    cause_t exp_cause [LQ_DEPTH];
    int     exp_dt [LQ_DEPTH], exp_dc [LQ_DEPTH], dt_cnt [LQ_DEPTH], dc_cnt [LQ_DEPTH];
    int     errors, checks, base;
    lq_idx_t next_id, front;
    logic   shown_q;               // result shown unclaimed last cycle
    logic [15:0] lfsr;
    lq_idx_t dt_id [$], dc_id [$];
    addr_t  dt_va [$], dc_pa [$];
    int     dt_dly [$], dc_dly [$];

    lsu_load_unit uut (
        .clk(clk), .rst(rst), .flush(flush),
        .issue_valid(issue_valid), .issue_ldid(issue_ldid),
        .issue_vaddr(issue_vaddr), .issue_size(issue_size),
        .dt_rqst_valid(dt_rqst_valid), .dt_rqst_id(dt_rqst_id), .dt_vadd(dt_vadd),
        .dt_resp_valid(dt_resp_valid), .dt_resp_id(dt_resp_id),
        .dt_padd(dt_padd), .dt_perm(dt_perm),
        .dc_rqst_valid(dc_rqst_valid), .dc_rqst_id(dc_rqst_id), .dc_addr(dc_addr),
        .dc_resp_valid(dc_resp_valid), .dc_resp_id(dc_resp_id), .dc_rdat(dc_rdat),
        .res_valid(res_valid), .res_ldid(res_ldid), .res_data(res_data),
        .res_cause(res_cause), .claim(claim), .commit_valid(commit_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // each memory byte is the sum of its address bytes
    function automatic logic [7:0] mem_byte(addr_t a);
        logic [7:0] s;
        s = '0;
        for (int b = 0; b < 8; b++) s += a[8*b +: 8];
        return s;
    endfunction

    function automatic data_t mem_word(addr_t a);   // already shifted to byte 0
        data_t w;
        for (int k = 0; k < 8; k++) w[8*k +: 8] = mem_byte(a + addr_t'(k));
        return w;
    endfunction

    function automatic data_t expect_ext(data_t w, ld_size_t sz);
        int bits;
        bits = 8 << sz[1:0];
        if (bits == 64) return w;
        if (sz[2]) return w & ((64'd1 << bits) - 64'd1);
        return data_t'($signed(w << (64 - bits)) >>> (64 - bits));
    endfunction

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int rand_delay();            // two LFSR bits, 0 to 3
        int d;
        d = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_next(lfsr);
            d = (d << 1) | int'(lfsr[0]);
        end
        return d;
    endfunction

    // DTLB and cache models, oldest expired request answered first
    always @(posedge clk) begin
        int hit;
        if (rst || flush) begin
            dt_id.delete(); dt_va.delete(); dt_dly.delete();
            dc_id.delete(); dc_pa.delete(); dc_dly.delete();
            dt_resp_valid <= 1'b0;
            dc_resp_valid <= 1'b0;
        end else begin
            hit = -1;
            foreach (dt_dly[i]) if (hit < 0 && dt_dly[i] == 0) hit = i;
            foreach (dt_dly[i]) if (dt_dly[i] > 0) dt_dly[i]--;
            dt_resp_valid <= hit >= 0;
            if (hit >= 0) begin
                dt_resp_id <= dt_id[hit];
                dt_padd    <= dt_va[hit] ^ (64'd1 << 40);
                dt_perm    <= fault[dt_id[hit]] ? 8'h41 : 8'h47;
                dt_id.delete(hit); dt_va.delete(hit); dt_dly.delete(hit);
            end
            hit = -1;
            foreach (dc_dly[i]) if (hit < 0 && dc_dly[i] == 0) hit = i;
            foreach (dc_dly[i]) if (dc_dly[i] > 0) dc_dly[i]--;
            dc_resp_valid <= hit >= 0;
            if (hit >= 0) begin
                dc_resp_id <= dc_id[hit];
                dc_rdat    <= mem_word(dc_pa[hit]);
                dc_id.delete(hit); dc_pa.delete(hit); dc_dly.delete(hit);
            end
            if (dt_rqst_valid) begin
                dt_id.push_back(dt_rqst_id);
                dt_va.push_back(dt_vadd);
                dt_dly.push_back(rand_delay());
            end
            if (dc_rqst_valid) begin
                dc_id.push_back(dc_rqst_id);
                dc_pa.push_back(dc_addr);
                dc_dly.push_back(rand_delay());
            end
        end
    end

    task automatic check_value(string name, logic [63:0] got_v, logic [63:0] exp_v);
        checks++;
        assert (got_v === exp_v) else begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got_v, exp_v);
            errors++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic check_result();
        lq_idx_t j;
        check_true(pending[res_ldid] && !got[res_ldid], "result for an index not in flight");
        check_true(ready[res_ldid], "result shown before its last response");
        if (!shown_q) begin                 // older ready slots must win
            for (int k = 0; k < LQ_DEPTH; k++) begin
                j = front + lq_idx_t'(k);
                if (j == res_ldid) break;
                check_true(!ready[j], "younger result passed a ready one");
            end
        end
        check_value("res_data", res_data, exp_data[res_ldid]);
        check_value("res_cause", res_cause, exp_cause[res_ldid]);
        check_value("dt_rqst count", dt_cnt[res_ldid], exp_dt[res_ldid]);
        check_value("dc_rqst count", dc_cnt[res_ldid], exp_dc[res_ldid]);
        got[res_ldid] = 1'b1;
    endtask

    always @(posedge clk) begin
        if (rst || flush) begin
            shown_q <= 1'b0;
            for (int i = 0; i < LQ_DEPTH; i++) ready[i] <= 1'b0;
        end else begin
            if (dt_rqst_valid) dt_cnt[dt_rqst_id]++;
            if (dc_rqst_valid) dc_cnt[dc_rqst_id]++;
            // a load is ready after its last expected event
            if (issue_valid && exp_dt[issue_ldid] == 0) ready[issue_ldid] <= 1'b1;
            if (dt_resp_valid && exp_dc[dt_resp_id] == 0) ready[dt_resp_id] <= 1'b1;
            if (dc_resp_valid) ready[dc_resp_id] <= 1'b1;
            if (res_valid && claim) begin
                check_result();
                ready[res_ldid] <= 1'b0;
            end
            shown_q <= res_valid && !claim;
        end
    end

    task automatic issue_load(addr_t va, ld_size_t sz, logic flt);
        lq_idx_t idx;
        logic    misal;
        idx   = next_id;
        misal = (va & ((64'd1 << sz[1:0]) - 64'd1)) != 0;
        check_true(!pending[idx], "issue to a slot still in use");
        fault[idx]   = flt;
        pending[idx] = 1'b1;
        got[idx]     = 1'b0;
        dt_cnt[idx]  = 0;
        dc_cnt[idx]  = 0;
        exp_dt[idx]  = misal ? 0 : 1;
        exp_dc[idx]  = (misal || flt) ? 0 : 1;
        exp_cause[idx] = misal ? 8'h84 : (flt ? 8'h8D : 8'h00);
        exp_data[idx]  = (misal || flt) ? '0 : expect_ext(mem_word(va ^ (64'd1 << 40)), sz);
        @(posedge clk);
        issue_valid <= 1'b1;
        issue_ldid  <= idx;
        issue_vaddr <= va;
        issue_size  <= sz;
        @(posedge clk);
        issue_valid <= 1'b0;
        next_id = next_id + 1'b1;
    endtask

    function automatic logic all_got();
        for (int i = 0; i < LQ_DEPTH; i++) if (pending[i] && !got[i]) return 1'b0;
        return 1'b1;
    endfunction

    // wait for every result, then commit from the front
    task automatic drain();
        int n;
        n = 0;
        while (!all_got() && n < 400) begin
            @(posedge clk);
            n++;
        end
        if (!all_got()) begin
            $display("Error at %0t ns: results still missing after %0d cycles", $time, n);
            errors++;
        end
        while (pending[front] && got[front]) begin
            @(posedge clk);
            commit_valid <= 1'b1;
            pending[front] = 1'b0;
            front = front + 1'b1;
        end
        @(posedge clk);
        commit_valid <= 1'b0;
    endtask

    task automatic report(string name);
        $display("test %s: %0d errors", name, errors - base);
        base = errors;
    endtask

    task automatic test_sizes();
        for (int s = 0; s < 7; s++) issue_load(64'h0000_0012_3456_7880, ld_size_t'(s), 1'b0);
        drain();
        for (int s = 0; s < 7; s++) issue_load(64'h0000_0000_0000_0040, ld_size_t'(s), 1'b0);
        drain();
        report("sizes");
    endtask

    task automatic test_misaligned();
        issue_load(64'h0000_0003_0000_1001, 3'd1, 1'b0);
        issue_load(64'h0000_0003_0000_1002, 3'd6, 1'b0);
        issue_load(64'h0000_0003_0000_1004, 3'd3, 1'b0);
        drain();
        report("misaligned");
    endtask

    task automatic test_fault();
        issue_load(64'h0000_0004_0000_2000, 3'd3, 1'b1);
        issue_load(64'h0000_0004_0000_2008, 3'd2, 1'b0);
        issue_load(64'h0000_0004_0000_2010, 3'd0, 1'b1);
        drain();
        report("page fault");
    endtask

    task automatic test_backpressure();
        lq_idx_t id0;
        data_t   d0;
        cause_t  c0;
        int      n;
        @(posedge clk);
        claim <= 1'b0;
        issue_load(64'h0000_0005_0000_3000, 3'd3, 1'b0);
        issue_load(64'h0000_0005_0000_3008, 3'd5, 1'b0);
        n = 0;
        @(negedge clk);
        while (!res_valid && n < 100) begin
            @(negedge clk);
            n++;
        end
        check_true(res_valid, "no result within 100 cycles");
        id0 = res_ldid;
        d0  = res_data;
        c0  = res_cause;
        repeat (20) begin
            @(negedge clk);
            check_value("res_valid", res_valid, 1'b1);
            check_value("res_ldid", res_ldid, id0);
            check_value("res_data", res_data, d0);
            check_value("res_cause", res_cause, c0);
        end
        @(posedge clk);
        claim <= 1'b1;
        drain();
        report("back-pressure");
    endtask

    task automatic test_reorder();
        for (int i = 0; i < LQ_DEPTH; i++) begin
            issue_load(64'h0000_0100_0000_0000 + 64'h1_0108 * i, ld_size_t'(i % 7), 1'b0);
        end
        drain();
        report("reorder");
    endtask

    task automatic test_flush();
        @(posedge clk);
        claim <= 1'b0;
        for (int i = 0; i < 4; i++) issue_load(64'h0000_0006_0000_4000 + 8 * i, 3'd3, 1'b0);
        repeat (3) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (int i = 0; i < LQ_DEPTH; i++) pending[i] = 1'b0;
        front   = '0;
        next_id = '0;
        repeat (12) begin
            @(negedge clk);
            check_true(!res_valid && !dt_rqst_valid && !dc_rqst_valid,
                       "request or result of a flushed load");
        end
        @(posedge clk);
        claim <= 1'b1;
        for (int i = 0; i < 3; i++) issue_load(64'h0000_0007_0000_5000 + 8 * i, 3'd2, 1'b0);
        drain();
        report("flush");
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        claim = 1'b1;
        commit_valid = 1'b0;
        issue_valid = 1'b0;
        issue_ldid = '0;
        issue_vaddr = '0;
        issue_size = '0;
        lfsr = 16'd43;
        errors = 0;
        checks = 0;
        base = 0;
        next_id = '0;
        front = '0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            pending[i] = 1'b0;
            got[i] = 1'b0;
            fault[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_sizes();
        test_misaligned();
        test_fault();
        test_backpressure();
        test_reorder();
        test_flush();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("Error: simulation did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* lsu_load.f */
source/lsu_pkg.sv
source/lq_bus_if.sv
source/load_dispatch.sv
source/load_slot.sv
source/lq_scheduler.sv
source/lsu_load_unit.sv
sim/lsu_load_properties.sv
sim/tb_lsu_load.sv

/* Makefile */
# Verilator build and run of the load unit testbench

TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := tb_lsu_load
FILELIST  := lsu_load.f
BUILD_DIR := obj_dir
LOG       := sim.log

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
